// ==== design/axi_adapter_pkg.sv ====
// shared types for the cache-side to AXI4 bridge
// bus widths, AXI channel structs and cache request/response structs

package axi_adapter_pkg;

  // bus widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned AXI_DATA_W = 64;
  localparam int unsigned STRB_W     = AXI_DATA_W / 8;
  localparam int unsigned ID_W       = 4;
  localparam int unsigned LEN_W      = 8;
  localparam int unsigned SIZE_W     = 3;
  localparam int unsigned BURST_W    = 2;
  localparam int unsigned RESP_W     = 2;

  // cache line geometry
  localparam int unsigned LINE_BEATS = 4;
  localparam logic [SIZE_W-1:0] BEAT_SIZE = 3'd3;

  // AXI encodings
  localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
  localparam logic [RESP_W-1:0]  RESP_OKAY  = 2'b00;

  typedef logic [LINE_BEATS-1:0][AXI_DATA_W-1:0] line_t;
  typedef logic [LINE_BEATS-1:0][STRB_W-1:0]     line_strb_t;

  typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
  } aw_chan_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [STRB_W-1:0]     strb;
    logic                  last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
  } ar_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]       id;
    logic [AXI_DATA_W-1:0] data;
    logic [RESP_W-1:0]     resp;
    logic                  last;
  } r_chan_t;

  // master side of the bus
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // slave side of the bus
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    ar_ready;
    logic    b_valid;
    b_chan_t b;
    logic    r_valid;
    r_chan_t r;
  } axi_rsp_t;

  // cache-side request, burst 0 is a single beat and 1 a whole line
  typedef struct packed {
    logic               burst;
    logic               we;
    logic [ADDR_W-1:0]  addr;
    line_t              wdata;
    line_strb_t         be;
    logic [SIZE_W-1:0]  size;
    logic [ID_W-1:0]    id;
  } mem_req_t;

  typedef struct packed {
    line_t           rdata;
    logic [ID_W-1:0] id;
    logic            err;
  } mem_rsp_t;

endpackage

// ==== design/spill_register.sv ====
// two-entry register slice for one valid/ready channel
// keeps full throughput, ready toward the source comes from state only

`timescale 1ns/1ps

module spill_register #(
  parameter type T      = logic,
  parameter bit  BYPASS = 1'b0
) (
  input  logic clk,
  input  logic reset_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (BYPASS) begin : g_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : g_slice
    logic a_full_q;
    logic b_full_q;
    T     a_data_q;
    T     b_data_q;
    logic a_fill;
    logic a_drain;
    logic b_fill;
    logic b_drain;

    // entry a takes new data, entry b holds the older beat on a stall
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk) begin
      if (reset_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill) begin
          a_full_q <= 1'b1;
        end else if (a_drain) begin
          a_full_q <= 1'b0;
        end
        if (b_fill) begin
          b_full_q <= 1'b1;
        end else if (b_drain) begin
          b_full_q <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    // b is always the older entry when both are full
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end

endmodule

// ==== design/axi_cut.sv ====
// register cut on all five AXI channels
// forward slices on AW, W and AR, backward slices on B and R

`timescale 1ns/1ps

module axi_cut #(
  parameter bit BYPASS = 1'b0
) (
  input  logic                      clk,
  input  logic                      reset_i,
  input  axi_adapter_pkg::axi_req_t slv_req_i,
  output axi_adapter_pkg::axi_rsp_t slv_rsp_o,
  output axi_adapter_pkg::axi_req_t mst_req_o,
  input  axi_adapter_pkg::axi_rsp_t mst_rsp_i
);

  import axi_adapter_pkg::*;

  spill_register #(.T(aw_chan_t), .BYPASS(BYPASS)) u_aw_slice (
    .clk     (clk),
    .reset_i (reset_i),
    .valid_i (slv_req_i.aw_valid),
    .ready_o (slv_rsp_o.aw_ready),
    .data_i  (slv_req_i.aw),
    .valid_o (mst_req_o.aw_valid),
    .ready_i (mst_rsp_i.aw_ready),
    .data_o  (mst_req_o.aw)
  );

  spill_register #(.T(w_chan_t), .BYPASS(BYPASS)) u_w_slice (
    .clk     (clk),
    .reset_i (reset_i),
    .valid_i (slv_req_i.w_valid),
    .ready_o (slv_rsp_o.w_ready),
    .data_i  (slv_req_i.w),
    .valid_o (mst_req_o.w_valid),
    .ready_i (mst_rsp_i.w_ready),
    .data_o  (mst_req_o.w)
  );

  // write response runs from the bus back to the adapter
  spill_register #(.T(b_chan_t), .BYPASS(BYPASS)) u_b_slice (
    .clk     (clk),
    .reset_i (reset_i),
    .valid_i (mst_rsp_i.b_valid),
    .ready_o (mst_req_o.b_ready),
    .data_i  (mst_rsp_i.b),
    .valid_o (slv_rsp_o.b_valid),
    .ready_i (slv_req_i.b_ready),
    .data_o  (slv_rsp_o.b)
  );

  spill_register #(.T(ar_chan_t), .BYPASS(BYPASS)) u_ar_slice (
    .clk     (clk),
    .reset_i (reset_i),
    .valid_i (slv_req_i.ar_valid),
    .ready_o (slv_rsp_o.ar_ready),
    .data_i  (slv_req_i.ar),
    .valid_o (mst_req_o.ar_valid),
    .ready_i (mst_rsp_i.ar_ready),
    .data_o  (mst_req_o.ar)
  );

  spill_register #(.T(r_chan_t), .BYPASS(BYPASS)) u_r_slice (
    .clk     (clk),
    .reset_i (reset_i),
    .valid_i (mst_rsp_i.r_valid),
    .ready_o (mst_req_o.r_ready),
    .data_i  (mst_rsp_i.r),
    .valid_o (slv_rsp_o.r_valid),
    .ready_i (slv_req_i.r_ready),
    .data_o  (slv_rsp_o.r)
  );

endmodule

// ==== design/mem_axi_adapter.sv ====
// cache-side request port to AXI4 master, one transaction at a time
// single-beat and whole-line reads and writes, completions on a response pulse

`timescale 1ns/1ps

module mem_axi_adapter (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  axi_adapter_pkg::mem_req_t req_data_i,
  output logic                      gnt_o,
  output logic                      busy_o,
  output logic                      rsp_valid_o,
  output axi_adapter_pkg::mem_rsp_t rsp_o,
  output axi_adapter_pkg::axi_req_t axi_req_o,
  input  axi_adapter_pkg::axi_rsp_t axi_rsp_i
);

  import axi_adapter_pkg::*;

  // byte offset bits inside a line, and the beat counter width
  localparam int unsigned LINE_OFF_W = $clog2(LINE_BEATS * STRB_W);
  localparam int unsigned BEAT_W     = $clog2(LINE_BEATS);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WAIT_B,
    ST_READ,
    ST_RESP
  } state_e;

  state_e            state_q;
  logic              aw_valid_q;
  logic              w_valid_q;
  logic              ar_valid_q;
  logic [BEAT_W-1:0] beat_q;

  mem_req_t req_q;
  line_t    rdata_q;
  logic     err_q;

  aw_chan_t addr_chan;
  logic     req_hs;
  logic     aw_hs;
  logic     w_hs;
  logic     b_hs;
  logic     ar_hs;
  logic     r_hs;
  logic     w_last;
  logic     aw_done;
  logic     w_done;

  assign gnt_o       = req_i && (state_q == ST_IDLE);
  assign busy_o      = (state_q != ST_IDLE);
  assign rsp_valid_o = (state_q == ST_RESP);

  assign req_hs = req_i && gnt_o;
  assign aw_hs  = axi_req_o.aw_valid && axi_rsp_i.aw_ready;
  assign w_hs   = axi_req_o.w_valid && axi_rsp_i.w_ready;
  assign b_hs   = axi_rsp_i.b_valid && axi_req_o.b_ready;
  assign ar_hs  = axi_req_o.ar_valid && axi_rsp_i.ar_ready;
  assign r_hs   = axi_rsp_i.r_valid && axi_req_o.r_ready;

  // a single write has one beat, a burst ends on the last line beat
  assign w_last  = !req_q.burst || (beat_q == BEAT_W'(LINE_BEATS - 1));
  assign aw_done = !aw_valid_q || aw_hs;
  assign w_done  = !w_valid_q || (w_hs && w_last);

  // shared address beat for AW and AR
  always_comb begin
    addr_chan.id    = req_q.id;
    addr_chan.burst = BURST_INCR;
    if (req_q.burst) begin
      addr_chan.addr = {req_q.addr[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
      addr_chan.len  = LEN_W'(LINE_BEATS - 1);
      addr_chan.size = BEAT_SIZE;
    end else begin
      addr_chan.addr = req_q.addr;
      addr_chan.len  = '0;
      addr_chan.size = req_q.size;
    end
  end

  always_comb begin
    axi_req_o.aw       = addr_chan;
    axi_req_o.aw_valid = aw_valid_q;
    axi_req_o.w.data   = req_q.wdata[beat_q];
    axi_req_o.w.strb   = req_q.be[beat_q];
    axi_req_o.w.last   = w_last;
    axi_req_o.w_valid  = w_valid_q;
    axi_req_o.b_ready  = (state_q == ST_WAIT_B);
    axi_req_o.ar       = ar_chan_t'(addr_chan);
    axi_req_o.ar_valid = ar_valid_q;
    axi_req_o.r_ready  = (state_q == ST_READ);
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= ST_IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      ar_valid_q <= 1'b0;
      beat_q     <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_hs) begin
            beat_q <= '0;
            if (req_data_i.we) begin
              state_q    <= ST_WRITE;
              aw_valid_q <= 1'b1;
              w_valid_q  <= 1'b1;
            end else begin
              state_q    <= ST_READ;
              ar_valid_q <= 1'b1;
            end
          end
        end
        ST_WRITE: begin
          // AW and W finish on their own, in any order
          if (aw_hs) begin
            aw_valid_q <= 1'b0;
          end
          if (w_hs) begin
            if (w_last) begin
              w_valid_q <= 1'b0;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
          if (aw_done && w_done) begin
            state_q <= ST_WAIT_B;
          end
        end
        ST_WAIT_B: begin
          if (b_hs) begin
            state_q <= ST_RESP;
          end
        end
        ST_READ: begin
          if (ar_hs) begin
            ar_valid_q <= 1'b0;
          end
          if (r_hs) begin
            beat_q <= beat_q + 1'b1;
            if (axi_rsp_i.r.last) begin
              state_q <= ST_RESP;
            end
          end
        end
        ST_RESP: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // captured request and collected read line
  always_ff @(posedge clk) begin
    if (req_hs) begin
      req_q   <= req_data_i;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end
    if (b_hs && (axi_rsp_i.b.resp != RESP_OKAY)) begin
      err_q <= 1'b1;
    end
    if (r_hs) begin
      rdata_q[beat_q] <= axi_rsp_i.r.data;
      if (axi_rsp_i.r.resp != RESP_OKAY) begin
        err_q <= 1'b1;
      end
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.id    = req_q.id;
  assign rsp_o.err   = err_q;

endmodule

// ==== design/axi_adapter_top.sv ====
// bridge top level
// request adapter followed by a register cut toward the AXI bus

`timescale 1ns/1ps

module axi_adapter_top #(
  parameter bit CUT_BYPASS = 1'b0
) (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  axi_adapter_pkg::mem_req_t req_data_i,
  output logic                      gnt_o,
  output logic                      busy_o,
  output logic                      rsp_valid_o,
  output axi_adapter_pkg::mem_rsp_t rsp_o,
  output axi_adapter_pkg::axi_req_t m_axi_req_o,
  input  axi_adapter_pkg::axi_rsp_t m_axi_rsp_i
);

  import axi_adapter_pkg::*;

  // adapter side of the cut
  axi_req_t adapter_req;
  axi_rsp_t adapter_rsp;

  mem_axi_adapter u_mem_axi_adapter (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .gnt_o       (gnt_o),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .axi_req_o   (adapter_req),
    .axi_rsp_i   (adapter_rsp)
  );

  axi_cut #(
    .BYPASS (CUT_BYPASS)
  ) u_axi_cut (
    .clk       (clk),
    .reset_i   (reset_i),
    .slv_req_i (adapter_req),
    .slv_rsp_o (adapter_rsp),
    .mst_req_o (m_axi_req_o),
    .mst_rsp_i (m_axi_rsp_i)
  );

endmodule

// ==== test/axi_mem_model.sv ====
// AXI4 slave memory for the bridge testbench
// 128 beats with random stalls on every channel and SLVERR when address bit 28 is set

`timescale 1ns/1ps

module axi_mem_model #(
  parameter logic [31:0] SEED = 32'h9257808b
) (
  input  logic                      clk,
  input  logic                      reset_i,
  input  axi_adapter_pkg::axi_req_t axi_req_i,
  output axi_adapter_pkg::axi_rsp_t axi_rsp_o
);

  import axi_adapter_pkg::*;

  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

  logic [AXI_DATA_W-1:0] mem [128];
  logic [31:0]           rng_q;
  logic [2:0]            go_q;
  aw_chan_t              aw_q;
  ar_chan_t              ar_q;
  logic                  aw_pend_q;
  logic                  b_pend_q;
  logic                  b_valid_q;
  logic                  ar_pend_q;
  logic                  r_valid_q;
  logic [LEN_W-1:0]      wcnt_q;
  logic [LEN_W-1:0]      rcnt_q;
  logic [6:0]            widx;
  logic [6:0]            ridx;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // fill pattern built from the full beat index
  initial begin
    for (int i = 0; i < 128; i++) begin
      mem[i] = {32'(i) * 32'h9e3779b9, ~32'(i)};
    end
  end

  assign widx = aw_q.addr[9:3] + wcnt_q[6:0];
  assign ridx = ar_q.addr[9:3] + rcnt_q[6:0];

  always_comb begin
    axi_rsp_o.aw_ready = go_q[0] && !aw_pend_q;
    // W only after its AW and one write at a time
    axi_rsp_o.w_ready  = go_q[1] && aw_pend_q && !b_pend_q;
    axi_rsp_o.ar_ready = go_q[2] && !ar_pend_q;
    axi_rsp_o.b_valid  = b_valid_q;
    axi_rsp_o.b.id     = aw_q.id;
    axi_rsp_o.b.resp   = aw_q.addr[28] ? RESP_SLVERR : RESP_OKAY;
    axi_rsp_o.r_valid  = r_valid_q;
    axi_rsp_o.r.id     = ar_q.id;
    axi_rsp_o.r.data   = mem[ridx];
    axi_rsp_o.r.resp   = ar_q.addr[28] ? RESP_SLVERR : RESP_OKAY;
    axi_rsp_o.r.last   = (rcnt_q == ar_q.len);
  end

  always @(posedge clk) begin
    if (reset_i) begin
      rng_q     <= SEED;
      go_q      <= '0;
      aw_pend_q <= 1'b0;
      b_pend_q  <= 1'b0;
      b_valid_q <= 1'b0;
      ar_pend_q <= 1'b0;
      r_valid_q <= 1'b0;
      wcnt_q    <= '0;
      rcnt_q    <= '0;
    end else begin
      rng_q <= xorshift32(rng_q);
      go_q  <= rng_q[2:0];
      if (axi_req_i.aw_valid && axi_rsp_o.aw_ready) begin
        aw_q      <= axi_req_i.aw;
        aw_pend_q <= 1'b1;
        wcnt_q    <= '0;
      end
      if (axi_req_i.w_valid && axi_rsp_o.w_ready) begin
        for (int b = 0; b < 8; b++) begin
          if (axi_req_i.w.strb[b]) begin
            mem[widx][b*8 +: 8] <= axi_req_i.w.data[b*8 +: 8];
          end
        end
        wcnt_q <= wcnt_q + 8'd1;
        if (axi_req_i.w.last) begin
          b_pend_q <= 1'b1;
        end
      end
      if (b_pend_q && !b_valid_q && rng_q[4]) begin
        b_valid_q <= 1'b1;
      end
      if (b_valid_q && axi_req_i.b_ready) begin
        b_valid_q <= 1'b0;
        b_pend_q  <= 1'b0;
        aw_pend_q <= 1'b0;
      end
      if (axi_req_i.ar_valid && axi_rsp_o.ar_ready) begin
        ar_q      <= axi_req_i.ar;
        ar_pend_q <= 1'b1;
        rcnt_q    <= '0;
      end
      // valid drops after each beat and comes back after a random gap
      if (ar_pend_q && !r_valid_q && rng_q[5]) begin
        r_valid_q <= 1'b1;
      end
      if (r_valid_q && axi_req_i.r_ready) begin
        r_valid_q <= 1'b0;
        rcnt_q    <= rcnt_q + 8'd1;
        if (axi_rsp_o.r.last) begin
          ar_pend_q <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== test/tb_axi_adapter_top.sv ====
// testbench for the cache-side to AXI4 bridge
// random requests checked against a shadow memory and AW checked at the bus handshake

`timescale 1ns/1ps

module tb_axi_adapter_top;

  import axi_adapter_pkg::*;

  localparam int N_TESTS        = 200;
  localparam int RESET_CYCLES   = 16;
  localparam int HANG_CYCLES    = 200;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_TESTS * 60;

  logic     clk;
  logic     reset_i;
  logic     req_i;
  mem_req_t req_data;
  logic     gnt;
  logic     busy;
  logic     rsp_valid;
  mem_rsp_t rsp;
  axi_req_t m_axi_req;
  axi_rsp_t m_axi_rsp;

  logic [AXI_DATA_W-1:0] shadow [128];
  logic [31:0]           rng_state;
  aw_chan_t              exp_aw;
  int                    errors;
  int                    cycles;
  int                    aw_count;
  int                    rsp_count;

  axi_adapter_top u_axi_adapter_top (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .req_data_i  (req_data),
    .gnt_o       (gnt),
    .busy_o      (busy),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .m_axi_req_o (m_axi_req),
    .m_axi_rsp_i (m_axi_rsp)
  );

  axi_mem_model #(.SEED(32'h9257808b)) u_axi_mem_model (
    .clk       (clk),
    .reset_i   (reset_i),
    .axi_req_i (m_axi_req),
    .axi_rsp_o (m_axi_rsp)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] strb);
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        old[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return old;
  endfunction

  task automatic compare_rsp(input mem_rsp_t act, input mem_rsp_t exp, input int test);
    if (act !== exp) begin
      $display("MISMATCH at %0t: test %0d rsp id %h err %b rdata %h, exp id %h err %b rdata %h",
               $time, test, act.id, act.err, act.rdata, exp.id, exp.err, exp.rdata);
      errors++;
    end
  endtask

  task automatic compare_axi_aw(input aw_chan_t act, input aw_chan_t exp);
    if (act !== exp) begin
      $display("MISMATCH at %0t: AW id %h addr %h len %0d size %0d burst %b, exp %h %h %0d %0d %b",
               $time, act.id, act.addr, act.len, act.size, act.burst,
               exp.id, exp.addr, exp.len, exp.size, exp.burst);
      errors++;
    end
  endtask

  // AW handshakes and response pulses sampled on the falling edge
  always @(negedge clk) begin
    if (!reset_i && m_axi_req.aw_valid && m_axi_rsp.aw_ready) begin
      aw_count++;
      compare_axi_aw(m_axi_req.aw, exp_aw);
    end
    if (!reset_i && rsp_valid) begin
      rsp_count++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    mem_req_t   r;
    mem_rsp_t   exp_rsp;
    logic [6:0] idx;
    logic [6:0] base;
    int         kind;
    int         prev_kind;
    int         waited;
    int         err_before;
    int         aw_before;
    int         passed;
    int         failed;
    bit         hung;

    rng_state = 32'h9257808b;
    reset_i   = 1'b1;
    req_i     = 1'b0;
    req_data  = '0;
    exp_aw    = '0;
    errors    = 0;
    cycles    = 0;
    aw_count  = 0;
    rsp_count = 0;
    passed    = 0;
    failed    = 0;
    hung      = 1'b0;
    prev_kind = 0;
    r         = '0;
    for (int i = 0; i < 128; i++) begin
      shadow[i] = {32'(i) * 32'h9e3779b9, ~32'(i)};
    end

    repeat (RESET_CYCLES) @(negedge clk);
    reset_i = 1'b0;

    // quiet bus before the first request
    repeat (8) begin
      @(negedge clk);
      if (gnt || busy || rsp_valid || m_axi_req.aw_valid || m_axi_req.w_valid ||
          m_axi_req.ar_valid) begin
        $display("after reset: grant, busy, response or an AXI valid is high with no request");
        errors++;
      end
    end

    for (int t = 0; t < N_TESTS && !hung; t++) begin
      err_before = errors;
      // a line write is always followed by a line read of the same line
      if (prev_kind == 2) begin
        kind = 3;
      end else begin
        kind = int'(next_random() & 32'd3);
        r.addr = '0;
        r.addr[2:0] = 3'(next_random());
        r.addr[9:3] = 7'(next_random());
        r.addr[28] = ((next_random() & 32'd7) == 32'd0);
      end
      r.we    = (kind == 0) || (kind == 2);
      r.burst = (kind >= 2);
      r.size  = SIZE_W'(next_random() & 32'd3);
      r.id    = ID_W'(next_random() & 32'hf);
      for (int b = 0; b < LINE_BEATS; b++) begin
        r.wdata[b] = {next_random(), next_random()};
        r.be[b]    = STRB_W'(next_random() & 32'hff);
      end

      idx  = r.addr[9:3];
      base = {idx[6:2], 2'b00};
      exp_aw.id    = r.id;
      exp_aw.burst = BURST_INCR;
      exp_aw.addr  = r.burst ? {r.addr[31:5], 5'b0} : r.addr;
      exp_aw.len   = r.burst ? LEN_W'(LINE_BEATS - 1) : '0;
      exp_aw.size  = r.burst ? BEAT_SIZE : r.size;
      exp_rsp       = '0;
      exp_rsp.id    = r.id;
      exp_rsp.err   = r.addr[28];
      case (kind)
        0: shadow[idx] = merge_bytes(shadow[idx], r.wdata[0], r.be[0]);
        1: exp_rsp.rdata[0] = shadow[idx];
        2: begin
          for (int b = 0; b < LINE_BEATS; b++) begin
            shadow[base + 7'(b)] = merge_bytes(shadow[base + 7'(b)], r.wdata[b], r.be[b]);
          end
        end
        default: begin
          for (int b = 0; b < LINE_BEATS; b++) begin
            exp_rsp.rdata[b] = shadow[base + 7'(b)];
          end
        end
      endcase
      aw_before = aw_count;

      @(negedge clk);
      req_i    = 1'b1;
      req_data = r;
      #1;
      if (!gnt) begin
        $display("test %0d: no grant while the bridge was idle", t);
        errors++;
      end
      @(negedge clk);
      req_i = 1'b0;

      waited = 0;
      while (!rsp_valid && waited < HANG_CYCLES) begin
        @(negedge clk);
        waited++;
      end
      if (!rsp_valid) begin
        $display("test %0d hang: no response within %0d cycles", t, HANG_CYCLES);
        hung = 1'b1;
        errors++;
      end else begin
        compare_rsp(rsp, exp_rsp, t);
        @(negedge clk);
        if (busy) begin
          $display("test %0d: busy still high after the response", t);
          errors++;
        end
        if (rsp_count != t + 1) begin
          $display("test %0d: %0d responses seen for %0d requests", t, rsp_count, t + 1);
          errors++;
        end
        if (aw_count - aw_before != (r.we ? 1 : 0)) begin
          $display("test %0d: wrong number of AW handshakes", t);
          errors++;
        end
      end
      prev_kind = kind;

      if (errors == err_before) begin
        passed++;
        $display("test %0d kind %0d addr %h: ok", t, kind, r.addr);
      end else begin
        failed++;
        $display("test %0d kind %0d addr %h: failed", t, kind, r.addr);
      end
    end

    $display("tests passed %0d failed %0d, check errors %0d", passed, failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/axi_adapter_pkg.sv
design/spill_register.sv
design/axi_cut.sv
design/mem_axi_adapter.sv
design/axi_adapter_top.sv
test/axi_mem_model.sv
test/tb_axi_adapter_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_axi_adapter_top \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0
